/* logic/elevator_pkg.sv */
// Building definitions shared by every RTL block of the floor request controller

package elevator_pkg;

    //////////////////////////////////////////////////
    // Building size
    //////////////////////////////////////////////////

    // Floors served by the car
    localparam int num_floors = 11;

    //////////////////////////////////////////////////
    // Floor types
    //////////////////////////////////////////////////

    // Floor index where 0 is the ground floor (floor 1)
    typedef logic [3:0] floor_t;

    // One bit per floor for buttons and lamps
    typedef logic [num_floors-1:0] floor_mask_t;

    // Floor with a valid flag for queue push and queue head
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } floor_entry_t;

endpackage

/* logic/car_pkg.sv */
// Car motion definitions imported wherever the state or status of the car is seen

package car_pkg;

    // Car states with stopped as the idle position
    typedef enum logic [1:0] {
        stopped     = 2'd0,
        moving_up   = 2'd1,
        moving_down = 2'd2,
        halted      = 2'd3
    } car_state_t;

    //////////////////////////////////////////////////
    // Car status seen by intake and queue
    //////////////////////////////////////////////////

    typedef struct packed {
        elevator_pkg::floor_t current_floor;
        // 1 means up
        logic                 direction;
        logic                 moving;
        // One-cycle strobe when the current floor is served
        logic                 serve;
        // Power off or emergency active
        logic                 halt;
    } car_status_t;

endpackage

/* logic/request_intake.sv */
// Latches call and panel lamps and queues at most one newly accepted floor per cycle
`timescale 1ns/1ps

module request_intake (
    input  logic                       clock,
    input  logic                       reset_n,
    input  elevator_pkg::floor_mask_t  floor_call_buttons,
    input  elevator_pkg::floor_mask_t  panel_buttons,
    input  car_pkg::car_status_t       status,
    output elevator_pkg::floor_mask_t  call_button_lights,
    output elevator_pkg::floor_mask_t  panel_button_lights,
    output elevator_pkg::floor_entry_t push
);
    import elevator_pkg::*;

    floor_mask_t pressed;
    floor_mask_t lit;
    floor_mask_t current_mask;
    floor_mask_t eligible;
    floor_mask_t serve_mask;
    floor_mask_t pick_mask;
    logic        pick_valid;
    floor_t      pick_floor;

    //////////////////////////////////////////////////
    // Acceptance
    //////////////////////////////////////////////////

    assign pressed      = floor_call_buttons | panel_buttons;
    assign lit          = call_button_lights | panel_button_lights;
    assign current_mask = floor_mask_t'(1) << status.current_floor;

    // A floor is refused if the car is there or one of its lamps already burns
    assign eligible = pressed & ~lit & ~current_mask;

    // Lowest floor wins, so scan from the top and let lower hits overwrite
    always_comb begin
        pick_valid = 1'b0;
        pick_floor = '0;
        for (int i = num_floors - 1; i >= 0; i--) begin
            if (eligible[i]) begin
                pick_valid = 1'b1;
                pick_floor = floor_t'(i);
            end
        end
    end

    assign pick_mask  = pick_valid ? current_mask_of(pick_floor) : '0;
    assign serve_mask = status.serve ? current_mask : '0;

    function automatic floor_mask_t current_mask_of(input floor_t floor);
        current_mask_of = floor_mask_t'(1) << floor;
    endfunction

    //////////////////////////////////////////////////
    // Lamp registers and push strobe
    //////////////////////////////////////////////////

    // The picked floor is never the current floor, so serve and set
    // never touch the same bit
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
            push                <= '0;
        end else if (status.halt) begin
            // Power off or emergency drops every pending request
            call_button_lights  <= '0;
            panel_button_lights <= '0;
            push                <= '0;
        end else begin
            call_button_lights  <= (call_button_lights & ~serve_mask)
                                 | (pick_mask & floor_call_buttons);
            panel_button_lights <= (panel_button_lights & ~serve_mask)
                                 | (pick_mask & panel_buttons);
            push.valid          <= pick_valid;
            push.floor          <= pick_floor;
        end
    end

endmodule

/* logic/request_queue.sv */
// First-in-first-out store of pending floors, presents the oldest floor to the car
`timescale 1ns/1ps

module request_queue (
    input  logic                       clock,
    input  logic                       reset_n,
    input  elevator_pkg::floor_entry_t push,
    input  car_pkg::car_status_t       status,
    output elevator_pkg::floor_entry_t head
);
    import elevator_pkg::*;

    localparam int ptr_width   = $clog2(num_floors);
    localparam int count_width = $clog2(num_floors + 1);

    // Entry storage, one slot per floor is always enough
    floor_t                 entries [num_floors];
    logic [ptr_width-1:0]   rd_ptr;
    logic [ptr_width-1:0]   wr_ptr;
    logic [count_width-1:0] count;
    logic                   do_push;
    logic                   do_pop;

    assign do_push = push.valid && !status.halt;
    assign do_pop  = status.serve && (count != '0);

    assign head.valid = (count != '0);
    assign head.floor = entries[rd_ptr];

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        if (ptr == ptr_width'(num_floors - 1)) begin
            next_ptr = '0;
        end else begin
            next_ptr = ptr + 1'b1;
        end
    endfunction

    //////////////////////////////////////////////////
    // Pointers and count
    //////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (status.halt) begin
            // Flush, halt drops every queued floor
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Push and pop together leave the count unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) begin
            entries[wr_ptr] <= push.floor;
        end
    end

endmodule

/* logic/travel_timer.sv */
// Counts the travel interval between adjacent floors and pulses expired at its end
`timescale 1ns/1ps

module travel_timer #(
    parameter int unsigned travel_cycles = 8
) (
    input  logic clock,
    input  logic reset_n,
    input  logic start,
    output logic expired
);

    localparam int cnt_width = $clog2(travel_cycles);

    logic [cnt_width-1:0] count;
    logic                 active;

    // Expired comes travel_cycles cycles after the start pulse
    assign expired = active && (count == '0);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count  <= '0;
            active <= 1'b0;
        end else if (start) begin
            count  <= cnt_width'(travel_cycles - 1);
            active <= 1'b1;
        end else if (active) begin
            // Reload on its own so consecutive floors keep the same pace
            if (count == '0) begin
                count <= cnt_width'(travel_cycles - 1);
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* logic/car_motion_fsm.sv */
// Car state machine that moves toward the queue head, serves floors and grants door requests
`timescale 1ns/1ps

module car_motion_fsm #(
    parameter int unsigned travel_cycles = 8
) (
    input  logic                       clock,
    input  logic                       reset_n,
    input  elevator_pkg::floor_entry_t head,
    input  logic                       expired,
    input  logic                       emergency_btn,
    input  logic                       power_switch,
    input  logic                       door_open_btn,
    input  logic                       door_close_btn,
    output car_pkg::car_status_t       status,
    output logic                       start,
    output logic                       moving,
    output logic                       direction,
    output elevator_pkg::floor_t       current_floor,
    output logic                       door_open_allowed,
    output logic                       door_close_allowed
);
    import elevator_pkg::*;
    import car_pkg::*;

    // A two-cycle leg leans on the timer's own reload instead
    localparam bit rearm_each_step = (travel_cycles > 2);

    car_state_t           state;
    car_state_t           state_next;
    floor_t               floor_next;
    logic                 dir_next;
    logic                 halt;
    logic                 arrive;
    logic                 serve;
    logic                 head_above;

    assign halt       = !power_switch || emergency_btn;
    assign arrive     = head.valid && (head.floor == current_floor);
    assign head_above = head.floor > current_floor;

    // Serve also covers a head that already matches while stopped
    assign serve  = arrive && !halt && (state != halted);
    assign moving = (state == moving_up) || (state == moving_down);

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        floor_next = current_floor;
        dir_next   = direction;
        start      = 1'b0;
        if (!power_switch) begin
            state_next = stopped;
        end else if (emergency_btn) begin
            state_next = halted;
        end else begin
            case (state)
                stopped: begin
                    if (head.valid && !arrive) begin
                        state_next = head_above ? moving_up : moving_down;
                        dir_next   = head_above;
                        start      = 1'b1;
                    end
                end
                moving_up, moving_down: begin
                    if (!head.valid || arrive) begin
                        state_next = stopped;
                    end else if (expired) begin
                        // One floor per travel interval
                        if (state == moving_up) begin
                            floor_next = current_floor + 1'b1;
                        end else begin
                            floor_next = current_floor - 1'b1;
                        end
                        start = rearm_each_step;
                    end
                end
                // Release of the emergency button
                default: state_next = stopped;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state         <= stopped;
            current_floor <= '0;
            direction     <= 1'b1;
        end else begin
            state         <= state_next;
            current_floor <= floor_next;
            direction     <= dir_next;
        end
    end

    //////////////////////////////////////////////////
    // Doors and status
    //////////////////////////////////////////////////

    // Doors only follow their buttons with the car stopped and powered
    assign door_open_allowed  = door_open_btn && (state == stopped) && !halt;
    assign door_close_allowed = door_close_btn && (state == stopped) && !halt;

    assign status = '{
        current_floor: current_floor,
        direction:     direction,
        moving:        moving,
        serve:         serve,
        halt:          halt
    };

endmodule

/* logic/floor_request_controller.sv */
// Top level of the floor request controller, joins intake, queue, travel timer and car FSM
`timescale 1ns/1ps

module floor_request_controller #(
    parameter int unsigned travel_cycles = 8
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t floor_call_buttons,
    input  elevator_pkg::floor_mask_t panel_buttons,
    input  logic                      door_open_btn,
    input  logic                      door_close_btn,
    input  logic                      emergency_btn,
    input  logic                      power_switch,
    output elevator_pkg::floor_mask_t call_button_lights,
    output elevator_pkg::floor_mask_t panel_button_lights,
    output elevator_pkg::floor_t      current_floor,
    output logic                      moving,
    output logic                      direction,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);
    import elevator_pkg::*;
    import car_pkg::*;

    car_status_t  status;
    floor_entry_t push;
    floor_entry_t head;
    logic         start;
    logic         expired;

    request_intake u_intake (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .status              (status),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .push                (push)
    );

    request_queue u_queue (
        .clock   (clock),
        .reset_n (reset_n),
        .push    (push),
        .status  (status),
        .head    (head)
    );

    travel_timer #(
        .travel_cycles (travel_cycles)
    ) u_timer (
        .clock   (clock),
        .reset_n (reset_n),
        .start   (start),
        .expired (expired)
    );

    car_motion_fsm #(
        .travel_cycles (travel_cycles)
    ) u_car (
        .clock              (clock),
        .reset_n            (reset_n),
        .head               (head),
        .expired            (expired),
        .emergency_btn      (emergency_btn),
        .power_switch       (power_switch),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .status             (status),
        .start              (start),
        .moving             (moving),
        .direction          (direction),
        .current_floor      (current_floor),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

/* verification/tb_clock_gen.sv */
// Clock and reset source for the floor request controller testbench, instanced by its top
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 4
) (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #(half_period) clock = ~clock;
    end

    // Reset is low from time zero and lifts on a falling edge
    initial begin
        reset_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset_n <= 1'b1;
    end

endmodule

/* verification/floor_request_controller_tb.sv */
// Testbench top for the floor request controller, run by the Makefile as the simulation top
`timescale 1ns/1ps

module floor_request_controller_tb;
    import elevator_pkg::*;

    localparam int          travel_cycles = 8;
    localparam int          wait_limit    = 300;
    localparam logic [31:0] seed          = 32'hfaae8d65;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    floor_t      current_floor;
    logic        moving;
    logic        direction;
    logic        door_open_allowed;
    logic        door_close_allowed;

    // Reference model of lamps, car position and pending floors
    logic [31:0] rng_state;
    floor_t      car_floor;
    floor_mask_t model_call;
    floor_mask_t model_panel;
    floor_t      order_q[$];

    tb_clock_gen #(.half_period(10), .reset_cycles(4)) clock_source (
        .clock   (clock),
        .reset_n (reset_n)
    );

    floor_request_controller #(.travel_cycles(travel_cycles)) UUT (.*);

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////

    task automatic abort_run(input string reason);
        $display(">>> FAIL");
        $fatal(1, "%s", reason);
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
        abort_run("value mismatch");
    endtask

    task automatic report_problem(input string what);
        $display("[FAIL] t=%0t %s", $time, what);
        abort_run(what);
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected)
        else report_mismatch(name, expected, actual);
    endtask

    task automatic check_lamps();
        check_value("call_button_lights", model_call, call_button_lights);
        check_value("panel_button_lights", model_panel, panel_button_lights);
    endtask

    // Door permission never coexists with motion, emergency or power off
    always @(posedge clock) begin
        if (reset_n) begin
            assert (!((door_open_allowed || door_close_allowed)
                      && (moving || emergency_btn || !power_switch)))
            else report_problem("door permission granted while moving or halted");
        end
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_floor(output floor_t f);
        rng_state = xorshift32(rng_state);
        f         = floor_t'(rng_state % num_floors);
    endtask

    task automatic draw_other_floor(output floor_t f);
        f = car_floor;
        for (int tries = 0; tries < 64 && f == car_floor; tries++) begin
            draw_floor(f);
        end
        if (f == car_floor) begin
            report_problem("random source kept returning the car floor");
        end
    endtask

    function automatic floor_t step_toward(input floor_t from, input floor_t target);
        if (target > from) begin
            return from + 4'd1;
        end else begin
            return from - 4'd1;
        end
    endfunction

    // One-cycle press, lamps are checked at the next falling edge
    task automatic press_floor(input floor_t f, input bit use_call, input bit use_panel);
        floor_mask_t f_mask;
        f_mask             = floor_mask_t'(1) << f;
        floor_call_buttons = use_call ? f_mask : '0;
        panel_buttons      = use_panel ? f_mask : '0;
        // Refused at the car's floor, on a lit floor and while the car is halted
        if (f != car_floor && ((model_call | model_panel) & f_mask) == '0
                && power_switch && !emergency_btn) begin
            model_call  = use_call ? (model_call | f_mask) : model_call;
            model_panel = use_panel ? (model_panel | f_mask) : model_panel;
            order_q.push_back(f);
        end
        @(negedge clock);
        check_lamps();
        floor_call_buttons = '0;
        panel_buttons      = '0;
    endtask

    task automatic travel_to(input floor_t target);
        floor_t      prev;
        floor_mask_t target_mask;
        int          cycles;
        prev        = car_floor;
        target_mask = floor_mask_t'(1) << target;
        cycles      = 0;
        forever begin
            @(negedge clock);
            cycles++;
            if (cycles > wait_limit) begin
                report_problem("car did not reach the requested floor in time");
            end
            if (current_floor != prev) begin
                // Exactly one floor per step, always toward the target
                check_value("current_floor", step_toward(prev, target), current_floor);
                prev = current_floor;
            end
            if (moving && current_floor != target) begin
                check_value("direction", int'(target > current_floor), direction);
            end
            if (!moving && current_floor == target) begin
                break;
            end
            check_lamps();
        end
        // Both lamps of the served floor go out on arrival
        model_call  &= ~target_mask;
        model_panel &= ~target_mask;
        car_floor    = target;
        check_lamps();
    endtask

    task automatic serve_all();
        floor_t target;
        while (order_q.size() > 0) begin
            target = order_q.pop_front();
            travel_to(target);
        end
    endtask

    task automatic idle_check(input int n);
        repeat (n) begin
            @(negedge clock);
            check_value("moving", 0, moving);
            check_value("current_floor", car_floor, current_floor);
            check_lamps();
        end
    endtask

    // Halts the car right after its first step, then releases it
    task automatic halt_during_travel(input bit by_power);
        int cycles;
        cycles = 0;
        while (current_floor == car_floor) begin
            @(negedge clock);
            cycles++;
            if (cycles > wait_limit) begin
                report_problem("car never left its floor");
            end
        end
        check_value("current_floor", step_toward(car_floor, order_q[0]), current_floor);
        car_floor = step_toward(car_floor, order_q[0]);
        if (by_power) begin
            power_switch = 1'b0;
        end else begin
            emergency_btn = 1'b1;
        end
        model_call  = '0;
        model_panel = '0;
        order_q.delete();
        press_floor((car_floor == 4'd0) ? 4'd1 : 4'd0, 1'b1, 1'b1);
        idle_check(5);
        power_switch  = 1'b1;
        emergency_btn = 1'b0;
        // Queue was flushed, so the car stays put
        idle_check(20);
    endtask

    task automatic doors_after_cycle(input bit open_exp, input bit close_exp);
        @(negedge clock);
        check_value("door_open_allowed", open_exp, door_open_allowed);
        check_value("door_close_allowed", close_exp, door_close_allowed);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        int     cycles;
        floor_t f;
        floor_t far_floor;

        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        rng_state          = seed;
        car_floor          = '0;
        model_call         = '0;
        model_panel        = '0;

        cycles = 0;
        while (reset_n !== 1'b1) begin
            @(negedge clock);
            cycles++;
            if (cycles > wait_limit) begin
                report_problem("reset was never released");
            end
        end

        check_lamps();
        check_value("current_floor", 0, current_floor);
        check_value("moving", 0, moving);
        check_value("direction", 1, direction);
        check_value("door_open_allowed", 0, door_open_allowed);
        check_value("door_close_allowed", 0, door_close_allowed);

        // Own floor is refused, then a single panel trip
        press_floor(car_floor, 1'b0, 1'b1);
        idle_check(3);
        draw_other_floor(f);
        press_floor(f, 1'b0, 1'b1);
        serve_all();

        // Presses one per cycle, stops must follow press order
        repeat (8) begin
            draw_floor(f);
            press_floor(f, rng_state[20], !rng_state[20]);
        end
        serve_all();

        // Call and panel on the same floor give a single stop
        draw_other_floor(f);
        press_floor(f, 1'b1, 1'b1);
        serve_all();
        idle_check(10);

        // Emergency first, then power off
        for (int by_power = 0; by_power < 2; by_power++) begin
            far_floor = (car_floor < 4'd5) ? 4'd10 : 4'd0;
            press_floor(far_floor, 1'b0, 1'b1);
            draw_other_floor(f);
            press_floor(f, 1'b1, 1'b0);
            halt_during_travel(by_power == 1);
        end

        door_open_btn = 1'b1;
        doors_after_cycle(1'b1, 1'b0);
        door_open_btn  = 1'b0;
        door_close_btn = 1'b1;
        doors_after_cycle(1'b0, 1'b1);
        door_open_btn = 1'b1;
        emergency_btn = 1'b1;
        doors_after_cycle(1'b0, 1'b0);
        emergency_btn = 1'b0;
        doors_after_cycle(1'b1, 1'b1);
        power_switch = 1'b0;
        doors_after_cycle(1'b0, 1'b0);
        power_switch = 1'b1;
        doors_after_cycle(1'b1, 1'b1);
        // Buttons held through a trip, the monitor watches the moving part
        draw_other_floor(f);
        press_floor(f, 1'b1, 1'b0);
        serve_all();
        check_value("door_open_allowed", 1, door_open_allowed);
        check_value("door_close_allowed", 1, door_close_allowed);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* floor_request_controller.f */
logic/elevator_pkg.sv
logic/car_pkg.sv
logic/request_intake.sv
logic/request_queue.sv
logic/travel_timer.sv
logic/car_motion_fsm.sv
logic/floor_request_controller.sv
verification/tb_clock_gen.sv
verification/floor_request_controller_tb.sv

/* Makefile */
# Verilator build and run of the floor request controller testbench

VERILATOR  ?= verilator
TOP        := floor_request_controller_tb
LINT_TOP   := floor_request_controller
FILELIST   := floor_request_controller.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the simulation is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
